// ==== design/tremolo_pkg.sv ====
package tremolo_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 8;        // one unsigned audio sample.
    localparam int DEPTH_W  = 5;        // holds 0 up to DEPTH_MAX.
    localparam int WIDE_W   = 16;       // room for the modulation product.

    ////////////////////////////////////////////////////////////
    // shared constants
    ////////////////////////////////////////////////////////////

    localparam int NUM_CHANNELS = 4;    // gain stages in the bank.
    localparam int DEPTH_MAX    = 16;   // top of the triangle sweep.
    localparam int DEPTH_SHIFT  = 4;    // product is divided by 16.
    localparam int TICK_DIV     = 8;    // clocks per sample tick.
    localparam int MID_SAMPLE   = 128;  // fold point of the modulation.
    localparam int SAMPLE_MAX   = (1 << SAMPLE_W) - 1;

    // Derived sizes for the divider and the mono sum.
    localparam int TICK_CNT_W = $clog2(TICK_DIV);
    localparam int CHAN_SHIFT = $clog2(NUM_CHANNELS);
    localparam int MIX_W      = SAMPLE_W + CHAN_SHIFT;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [SAMPLE_W-1:0] sample_t;  // channel and mono samples.
    typedef logic [DEPTH_W-1:0]  depth_t;   // current tremolo depth.
    typedef logic [WIDE_W-1:0]   wide_t;    // intermediate arithmetic.

endpackage

// ==== design/lfo_triangle.sv ====
`timescale 1ns/1ps

module lfo_triangle
    import tremolo_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   en,
    output logic   tick,
    output depth_t depth
);

    ////////////////////////////////////////////////////////////
    // sample tick divider
    ////////////////////////////////////////////////////////////

    logic [TICK_CNT_W-1:0] div_cnt;     // clocks left until the next tick.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= TICK_CNT_W'(TICK_DIV - 1);    // first tick lands TICK_DIV cycles out.
        end else if (div_cnt == '0) begin
            div_cnt <= TICK_CNT_W'(TICK_DIV - 1);    // reload on the tick cycle.
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    // The divider runs freely, so the tick keeps its rate while en is low.
    assign tick = (div_cnt == '0);

    ////////////////////////////////////////////////////////////
    // triangle depth
    ////////////////////////////////////////////////////////////

    logic   dir_up;                     // high while the sweep climbs.
    logic   dir_up_next;
    depth_t depth_next;

    always_comb begin
        depth_next  = depth;
        dir_up_next = dir_up;
        if (tick && en) begin
            if (dir_up && (depth < depth_t'(DEPTH_MAX))) begin
                depth_next = depth + 1'b1;              // still climbing.
            end else if (depth == depth_t'(DEPTH_MAX)) begin
                dir_up_next = 1'b0;                     // top reached, turn around.
                depth_next  = depth - 1'b1;
            end else if (!dir_up && (depth > '0)) begin
                depth_next = depth - 1'b1;              // still falling.
            end else if (depth == '0) begin
                dir_up_next = 1'b1;                     // bottom reached, climb again.
                depth_next  = depth + 1'b1;
            end
        end
    end

    // Depth moves on the edge that closes the tick cycle, so the gain
    // stages see the old value while they sample.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            depth  <= '0;
            dir_up <= 1'b1;                             // sweep starts upward.
        end else begin
            depth  <= depth_next;
            dir_up <= dir_up_next;
        end
    end

endmodule

// ==== design/tremolo_gain.sv ====
`timescale 1ns/1ps

module tremolo_gain
    import tremolo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    tick,
    input  logic    en,
    input  depth_t  depth,
    input  sample_t sample_in,
    output sample_t sample_out,
    output logic    sample_valid
);

    ////////////////////////////////////////////////////////////
    // folded modulation
    ////////////////////////////////////////////////////////////

    wide_t sample_w;                    // input sample widened.
    wide_t depth_w;                     // depth widened.
    wide_t fold_base;                   // value at zero depth.
    wide_t swing;                       // distance from the fold point.
    wide_t product;
    wide_t mod_val;

    always_comb begin
        sample_w = wide_t'(sample_in);
        depth_w  = wide_t'(depth);
        if (sample_w >= wide_t'(MID_SAMPLE)) begin
            fold_base = wide_t'(SAMPLE_MAX) - sample_w;     // upper half is mirrored.
            swing     = sample_w - wide_t'(MID_SAMPLE);
        end else begin
            fold_base = sample_w;                           // lower half passes through.
            swing     = wide_t'(MID_SAMPLE - 1) - sample_w;
        end
        product = (swing << 1) * depth_w;                   // twice the swing, scaled by depth.
        mod_val = fold_base + (product >> DEPTH_SHIFT);     // divide by 16 rounds down.
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_out   <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= tick;                           // one cycle behind the tick.
            if (tick) begin
                if (en) begin
                    sample_out <= sample_t'(mod_val);       // keep the low 8 bits.
                end else begin
                    sample_out <= '0;                       // muted while disabled.
                end
            end
        end
    end

endmodule

// ==== design/channel_mixer.sv ====
`timescale 1ns/1ps

module channel_mixer
    import tremolo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  sample_t chan_in [NUM_CHANNELS],
    output sample_t chan_out [NUM_CHANNELS],
    output sample_t mono_out,
    output logic    out_valid
);

    ////////////////////////////////////////////////////////////
    // mono sum
    ////////////////////////////////////////////////////////////

    logic [MIX_W-1:0] mix_sum;          // wide enough for every channel at full scale.
    logic [MIX_W-1:0] mix_mean;

    always_comb begin
        mix_sum = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            mix_sum = mix_sum + MIX_W'(chan_in[i]);
        end
    end

    // Channel count is a power of two, so the mean is a plain shift.
    assign mix_mean = mix_sum >> CHAN_SHIFT;

    ////////////////////////////////////////////////////////////
    // output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                chan_out[i] <= '0;
            end
            mono_out  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;                      // strobe follows the capture.
            if (in_valid) begin
                for (int i = 0; i < NUM_CHANNELS; i++) begin
                    chan_out[i] <= chan_in[i];
                end
                mono_out <= sample_t'(mix_mean);        // mean never exceeds one sample.
            end
        end
    end

endmodule

// ==== design/tremolo_bank.sv ====
`timescale 1ns/1ps

module tremolo_bank
    import tremolo_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    en,
    input  sample_t audio_in [NUM_CHANNELS],
    output sample_t audio_out [NUM_CHANNELS],
    output sample_t mono_out,
    output logic    out_valid
);

    logic                    tick;          // sample strobe from the LFO.
    depth_t                  depth;         // shared tremolo depth.
    sample_t                 gain_out [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] gain_valid;    // all bits move together.

    ////////////////////////////////////////////////////////////
    // oscillator
    ////////////////////////////////////////////////////////////

    lfo_triangle u_lfo (
        .clk   (clk),
        .rst   (rst),
        .en    (en),
        .tick  (tick),
        .depth (depth)
    );

    ////////////////////////////////////////////////////////////
    // per channel gain stages
    ////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        tremolo_gain u_gain (
            .clk          (clk),
            .rst          (rst),
            .tick         (tick),
            .en           (en),
            .depth        (depth),
            .sample_in    (audio_in[ch]),
            .sample_out   (gain_out[ch]),
            .sample_valid (gain_valid[ch])
        );
    end

    ////////////////////////////////////////////////////////////
    // mixer
    ////////////////////////////////////////////////////////////

    // Channel 0 speaks for the whole set since every stage shares the tick.
    channel_mixer u_mixer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (gain_valid[0]),
        .chan_in   (gain_out),
        .chan_out  (audio_out),
        .mono_out  (mono_out),
        .out_valid (out_valid)
    );

endmodule

// ==== bench/tremolo_bank_assert.sv ====
`timescale 1ns/1ps

module tremolo_bank_assert
    import tremolo_pkg::*;
(
    input logic                    clk,
    input logic                    rst,
    input logic                    tick,
    input depth_t                  depth,
    input logic [NUM_CHANNELS-1:0] gain_valid
);

    ////////////////////////////////////////////////////////////
    // strobe properties
    ////////////////////////////////////////////////////////////

    tick_single: assert property (@(posedge clk) disable iff (rst) tick |=> !tick)
        else $error("tick was high in two consecutive cycles");

    // every gain stage shares the tick, so the valid bits move as one.
    valid_agree: assert property (@(posedge clk) disable iff (rst)
        ((&gain_valid) || !(|gain_valid)))
        else $error("gain_valid bits disagree: %b", gain_valid);

    ////////////////////////////////////////////////////////////
    // depth properties
    ////////////////////////////////////////////////////////////

    depth_range: assert property (@(posedge clk) disable iff (rst)
        (depth <= depth_t'(DEPTH_MAX)))
        else $error("depth %0d is above the top of the sweep", depth);

    depth_after_tick: assert property (@(posedge clk) disable iff (rst)
        (depth != $past(depth)) |-> $past(tick))
        else $error("depth changed without a tick in the previous cycle");

endmodule

bind tremolo_bank tremolo_bank_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .depth      (depth),
    .gain_valid (gain_valid)
);

// ==== bench/tremolo_bank_tb.sv ====
`timescale 1ns/1ps

module tremolo_bank_tb
    import tremolo_pkg::*;
();

    localparam int RESET_CYCLES = 2;
    localparam int WAIT_LIMIT   = 4 * TICK_DIV;    // a strobe later than this is lost.

    logic    clk;
    logic    rst;
    logic    en;
    sample_t audio_in [NUM_CHANNELS];
    sample_t audio_out [NUM_CHANNELS];
    sample_t mono_out;
    logic    out_valid;

    int      checks;
    int      errors;
    int      timeouts;
    int      last_wait;                 // falling edges spent in the latest wait.
    integer  seed;

    depth_t  model_depth;               // depth the next tick will use.
    logic    model_up;
    sample_t stim [NUM_CHANNELS];       // samples for the next tick.
    logic    stim_en;

    always #50 clk = ~clk;

    tremolo_bank u_dut (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .audio_in  (audio_in),
        .audio_out (audio_out),
        .mono_out  (mono_out),
        .out_valid (out_valid)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic sample_t expect_gain(int s, int d, logic on);
        int r;
        if (!on) begin
            return '0;                  // muted output.
        end
        if (s >= 128) begin
            r = (255 - s) + (2 * (s - 128) * d) / 16;
        end else begin
            r = s + (2 * (127 - s) * d) / 16;
        end
        return sample_t'(r);            // only the low 8 bits survive.
    endfunction

    // Inverts the rule for a full scale sample, which rises strictly with depth.
    function automatic depth_t decode_depth(sample_t v);
        for (int d = 0; d <= DEPTH_MAX; d++) begin
            if (expect_gain(255, d, 1'b1) == v) begin
                return depth_t'(d);
            end
        end
        return '1;                      // no depth gives this value.
    endfunction

    task automatic step_model();
        if (model_up) begin
            if (model_depth < DEPTH_MAX) begin
                model_depth++;
            end else begin
                model_up = 1'b0;        // turn at the top.
                model_depth--;
            end
        end else begin
            if (model_depth > 0) begin
                model_depth--;
            end else begin
                model_up = 1'b1;        // turn at the bottom.
                model_depth++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_sample(input sample_t exp, input sample_t got, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    task automatic check_depth_seq(input depth_t exp, input depth_t got, input int step);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0d ns: depth at step %0d expected %0d got %0d",
                     $time, step, exp, got);
        end
    endtask

    task automatic check_count(input int exp, input int got, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %0d ns: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic wait_out_valid(output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (out_valid === 1'b1) begin
                ok = 1'b1;
            end
        end
        last_wait = n;
        if (!ok) begin
            errors++;
            timeouts++;
            $display("timeout: out_valid never pulsed within %0d cycles, at %0d ns",
                     WAIT_LIMIT, $time);
        end
    endtask

    // Called on a falling edge; the inputs stay put until the next tick takes them.
    task automatic run_set(input string tag);
        sample_t exp_chan [NUM_CHANNELS];
        int      sum;
        logic    ok;
        sum = 0;
        en  = stim_en;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            audio_in[ch] = stim[ch];
            exp_chan[ch] = expect_gain(stim[ch], model_depth, stim_en);
            sum += exp_chan[ch];
        end
        wait_out_valid(ok);
        if (ok) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                check_sample(exp_chan[ch], audio_out[ch], $sformatf("%s ch%0d", tag, ch));
            end
            check_sample(sample_t'(sum / NUM_CHANNELS), mono_out, {tag, " mono"});
        end
        if (stim_en) begin
            step_model();               // depth only moves while enabled.
        end
    endtask

    task automatic report_test(input string name, input int base);
        $display("test %s finished with %0d errors", name, errors - base);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int base;
        base        = errors;
        model_depth = '0;
        model_up    = 1'b1;
        stim        = '{8'd0, 8'd100, 8'd200, 8'd255};
        stim_en     = 1'b1;
        rst         = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_count(0, int'(out_valid), "out_valid during reset");
        end
        rst = 1'b0;
        run_set("reset");
        // tick shows after the divider runs down, out_valid two cycles later.
        check_count(TICK_DIV + 1, last_wait, "cycles to first out_valid");
        report_test("reset_state", base);
    endtask

    task automatic test_modulation();
        int      base;
        sample_t values [6];
        base    = errors;
        values  = '{8'd0, 8'd100, 8'd127, 8'd128, 8'd200, 8'd255};
        stim_en = 1'b1;
        for (int p = 0; p < 20; p++) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                stim[ch] = values[(p + ch) % 6];
            end
            run_set($sformatf("modulation pulse %0d", p));
        end
        report_test("modulation", base);
    endtask

    task automatic test_triangle();
        int     base;
        depth_t used;
        depth_t got;
        logic   hit_top;
        logic   hit_bottom;
        base       = errors;
        hit_top    = 1'b0;
        hit_bottom = 1'b0;
        stim       = '{8'd255, 8'd255, 8'd255, 8'd255};
        stim_en    = 1'b1;
        for (int p = 0; p < 40; p++) begin
            used = model_depth;
            run_set($sformatf("triangle pulse %0d", p));
            got = decode_depth(audio_out[0]);
            check_depth_seq(used, got, p);
            if (got == depth_t'(DEPTH_MAX)) begin
                hit_top = 1'b1;             // the output showed the top of the sweep.
            end
            if (got == '0) begin
                hit_bottom = 1'b1;
            end
        end
        check_count(1, int'(hit_top && hit_bottom), "both turning points reached");
        report_test("triangle", base);
    endtask

    task automatic test_enable();
        int     base;
        depth_t held;
        base    = errors;
        stim    = '{8'd255, 8'd60, 8'd180, 8'd128};
        held    = model_depth;
        stim_en = 1'b0;
        for (int p = 0; p < 4; p++) begin
            run_set($sformatf("disabled pulse %0d", p));
        end
        stim_en = 1'b1;
        for (int p = 0; p < 4; p++) begin
            run_set($sformatf("enabled pulse %0d", p));
            if (p == 0) begin
                check_depth_seq(held, decode_depth(audio_out[0]), p);
            end
        end
        report_test("enable", base);
    endtask

    task automatic test_mono_mix();
        int base;
        base    = errors;
        stim_en = 1'b1;
        for (int p = 0; p < 16; p++) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                stim[ch] = sample_t'($random(seed));
            end
            run_set($sformatf("mono pulse %0d", p));
        end
        report_test("mono_mix", base);
    endtask

    task automatic test_spacing();
        int base;
        base    = errors;
        stim    = '{8'd10, 8'd90, 8'd170, 8'd250};
        stim_en = 1'b1;
        for (int p = 0; p < 10; p++) begin
            run_set($sformatf("spacing pulse %0d", p));
            check_count(TICK_DIV, last_wait, $sformatf("gap before pulse %0d", p));
        end
        report_test("spacing", base);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed      = 3;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        last_wait = 0;
        clk       = 1'b0;
        rst       = 1'b1;
        en        = 1'b0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            audio_in[ch] = '0;
        end
        test_reset_state();
        test_modulation();
        test_triangle();
        test_enable();
        test_mono_mix();
        test_spacing();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tremolo_bank.f ====
design/tremolo_pkg.sv
design/lfo_triangle.sv
design/tremolo_gain.sv
design/channel_mixer.sv
design/tremolo_bank.sv
bench/tremolo_bank_assert.sv
bench/tremolo_bank_tb.sv

// ==== Bender.yml ====
package:
  name: tremolo_bank

sources:
  # shared package first, then the RTL from the leaves up to the top level
  - design/tremolo_pkg.sv
  - design/lfo_triangle.sv
  - design/tremolo_gain.sv
  - design/channel_mixer.sv
  - design/tremolo_bank.sv

  # bench sources only pulled in for simulation
  - target: test
    files:
      - bench/tremolo_bank_assert.sv
      - bench/tremolo_bank_tb.sv
